// File: Bender.yml
package:
  name: writeAddrChannel

sources:
  - source/axiPkg.sv
  - source/awArbiter.sv
  - source/awDecoder.sv
  - source/writeAddrChannel.sv
  - target: test
    files:
      - dv/writeAddrChannelTb.sv

// File: build.f
source/axiPkg.sv
source/awArbiter.sv
source/awDecoder.sv
source/writeAddrChannel.sv
dv/writeAddrChannelTb.sv

// File: dv/writeAddrChannelTb.sv
`timescale 1ns/1ps

module writeAddrChannelTb;
    import axiPkg::*;

    // master request as seen on the master port
    typedef struct packed {
        idT    id;
        addrT  addr;
        lenT   len;
        sizeT  size;
        burstT burst;
    } reqT;

    localparam int routingCount  = 10;
    localparam int defaultCount  = 8;
    localparam int fairCount     = 40;
    localparam int randomCount   = 300;
    localparam int timeoutCycles =
        4 * (routingCount + defaultCount + fairCount + randomCount) + 200;

    logic clk;
    logic rstN;

    idT         mId    [2];
    addrT       mAddr  [2];
    lenT        mLen   [2];
    sizeT       mSize  [2];
    burstT      mBurst [2];
    logic [1:0] mValid;
    wire  [1:0] mReady;

    // index 0 to 4 are S1 to S5, index 5 is SD
    wire [7:0]  sId    [6];
    wire [31:0] sAddr  [6];
    wire [3:0]  sLen   [6];
    wire [2:0]  sSize  [6];
    wire [1:0]  sBurst [6];
    wire [5:0]  sValid;
    logic [5:0] sReady;

    reqT         issueQ0 [$];
    reqT         issueQ1 [$];
    reqT         actReq  [2];
    logic [1:0]  active;
    logic [1:0]  accepted;
    int          delivered [2];
    int          issuePct;
    logic        forceReady;
    logic        checkAlternate;
    int          expectMaster;
    logic        holdValid;
    int          holdSel;
    logic [48:0] holdPayload;
    int          errCount;
    int          testsPassed;
    int          testsFailed;
    int          cycleCount;

    writeAddrChannel writeAddrChannel_i (
        .clk(clk),
        .rstN(rstN),
        .awIdM0(mId[0]), .awAddrM0(mAddr[0]), .awLenM0(mLen[0]), .awSizeM0(mSize[0]),
        .awBurstM0(mBurst[0]), .awValidM0(mValid[0]), .awReadyM0(mReady[0]),
        .awIdM1(mId[1]), .awAddrM1(mAddr[1]), .awLenM1(mLen[1]), .awSizeM1(mSize[1]),
        .awBurstM1(mBurst[1]), .awValidM1(mValid[1]), .awReadyM1(mReady[1]),
        .awIdS1(sId[0]), .awAddrS1(sAddr[0]), .awLenS1(sLen[0]), .awSizeS1(sSize[0]),
        .awBurstS1(sBurst[0]), .awValidS1(sValid[0]), .awReadyS1(sReady[0]),
        .awIdS2(sId[1]), .awAddrS2(sAddr[1]), .awLenS2(sLen[1]), .awSizeS2(sSize[1]),
        .awBurstS2(sBurst[1]), .awValidS2(sValid[1]), .awReadyS2(sReady[1]),
        .awIdS3(sId[2]), .awAddrS3(sAddr[2]), .awLenS3(sLen[2]), .awSizeS3(sSize[2]),
        .awBurstS3(sBurst[2]), .awValidS3(sValid[2]), .awReadyS3(sReady[2]),
        .awIdS4(sId[3]), .awAddrS4(sAddr[3]), .awLenS4(sLen[3]), .awSizeS4(sSize[3]),
        .awBurstS4(sBurst[3]), .awValidS4(sValid[3]), .awReadyS4(sReady[3]),
        .awIdS5(sId[4]), .awAddrS5(sAddr[4]), .awLenS5(sLen[4]), .awSizeS5(sSize[4]),
        .awBurstS5(sBurst[4]), .awValidS5(sValid[4]), .awReadyS5(sReady[4]),
        .awIdSD(sId[5]), .awAddrSD(sAddr[5]), .awLenSD(sLen[5]), .awSizeSD(sSize[5]),
        .awBurstSD(sBurst[5]), .awValidSD(sValid[5]), .awReadySD(sReady[5])
    );

    // starts high so the first edge is a falling one
    initial begin
        clk = 1'b1;
        forever #20 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount <= timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: no result after %0d clock cycles", timeoutCycles);
        $display(">>> FAIL");
        $finish;
    end

    function automatic addrT baseOf(int k);
        case (k)
            0: return s1Base;
            1: return s2Base;
            2: return s3Base;
            3: return s4Base;
            default: return s5Base;
        endcase
    endfunction

    function automatic addrT limitOf(int k);
        case (k)
            0: return s1Limit;
            1: return s2Limit;
            2: return s3Limit;
            3: return s4Limit;
            default: return s5Limit;
        endcase
    endfunction

    // 5 means the default slave
    function automatic int expectedSlave(addrT addr);
        for (int k = 0; k < 5; k++) begin
            if (addr >= baseOf(k) && addr <= limitOf(k)) begin
                return k;
            end
        end
        return 5;
    endfunction

    function automatic addrT addrInSlave(int k);
        return baseOf(k) + ($urandom % (limitOf(k) - baseOf(k) + 1));
    endfunction

    function automatic addrT randomAddr();
        if ($urandom_range(1) == 0) begin
            return addrInSlave($urandom_range(4));
        end
        return $urandom;
    endfunction

    function automatic addrT unmappedAddr();
        addrT addr;
        addr = $urandom;
        while (expectedSlave(addr) != 5) begin
            addr = $urandom;
        end
        return addr;
    endfunction

    function automatic reqT makeRequest(addrT addr);
        reqT r;
        r.id    = $urandom;
        r.addr  = addr;
        r.len   = $urandom;
        r.size  = $urandom;
        r.burst = $urandom;
        return r;
    endfunction

    function automatic void queueRequest(int m, reqT r);
        if (m == 0) begin
            issueQ0.push_back(r);
        end else begin
            issueQ1.push_back(r);
        end
    endfunction

    function automatic int pendingCount(int m);
        return (m == 0) ? issueQ0.size() : issueQ1.size();
    endfunction

    function automatic reqT popRequest(int m);
        if (m == 0) begin
            return issueQ0.pop_front();
        end
        return issueQ1.pop_front();
    endfunction

    task automatic reportError(string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errCount++;
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        mValid = 2'b00;
        sReady = 6'b0;
        active = 2'b00;
        accepted = 2'b00;
        holdValid = 1'b0;
        expectMaster = 0;
        repeat (5) begin
            @(negedge clk);
            if (sValid != 6'b0 || mReady != 2'b00) begin
                reportError("slave valid or master ready high during reset");
            end
            @(posedge clk);
        end
        #2;
        rstN = 1'b1;
    endtask

    // sampled at the falling edge, so this is what the next rising edge sees
    task automatic checkSlaveSide();
        int          nValid;
        int          sel;
        int          m;
        reqT         exp;
        logic [48:0] payload;
        nValid = 0;
        sel = 0;
        // a request retires on its master-side handshake
        accepted = mValid & mReady;
        for (int k = 0; k < 6; k++) begin
            if (sValid[k]) begin
                nValid++;
                sel = k;
            end
        end
        if (mValid == 2'b00) begin
            if (nValid != 0 || mReady != 2'b00) begin
                reportError("slave valid or master ready high with no request");
            end
        end else if (nValid != 1) begin
            reportError($sformatf("%0d slave valids high, expected one", nValid));
        end else begin
            m = sId[sel][7:4];
            if (m > 1 || !mValid[m]) begin
                reportError($sformatf("slave ID %h names no requesting master", sId[sel]));
            end else begin
                exp = actReq[m];
                payload = {sId[sel], sAddr[sel], sLen[sel], sSize[sel], sBurst[sel]};
                if (payload != {idT'(m), exp}) begin
                    reportError($sformatf("slave payload %h, expected %h",
                        payload, {idT'(m), exp}));
                end
                if (expectedSlave(exp.addr) != sel) begin
                    reportError($sformatf("address %h routed to slave %0d, expected %0d",
                        exp.addr, sel, expectedSlave(exp.addr)));
                end
                if (mReady[m] != sReady[sel]) begin
                    reportError($sformatf("master %0d ready differs from slave ready", m));
                end
                if (mReady[1 - m]) begin
                    reportError($sformatf("losing master %0d sees ready high", 1 - m));
                end
                if (holdValid && (sel != holdSel || payload != holdPayload)) begin
                    reportError("slave side changed before the handshake");
                end
                if (sReady[sel]) begin
                    delivered[m]++;
                    holdValid = 1'b0;
                    if (checkAlternate) begin
                        if (m != expectMaster) begin
                            reportError($sformatf("master %0d won, expected master %0d",
                                m, expectMaster));
                        end
                        expectMaster = 1 - m;
                    end
                end else begin
                    holdValid = 1'b1;
                    holdSel = sel;
                    holdPayload = payload;
                end
            end
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        for (int m = 0; m < 2; m++) begin
            if (accepted[m]) begin
                active[m] = 1'b0;
            end
        end
        #2;
        for (int m = 0; m < 2; m++) begin
            if (!active[m] && pendingCount(m) > 0 && $urandom_range(99) < issuePct) begin
                actReq[m] = popRequest(m);
                active[m] = 1'b1;
            end
            mValid[m] = active[m];
            mId[m]    = actReq[m].id;
            mAddr[m]  = actReq[m].addr;
            mLen[m]   = actReq[m].len;
            mSize[m]  = actReq[m].size;
            mBurst[m] = actReq[m].burst;
        end
        for (int k = 0; k < 6; k++) begin
            sReady[k] = forceReady || ($urandom_range(1) == 1);
        end
        @(negedge clk);
        checkSlaveSide();
    endtask

    task automatic drainTraffic();
        while (issueQ0.size() > 0 || issueQ1.size() > 0 || active != 2'b00) begin
            stepCycle();
        end
    endtask

    task automatic finishTest(string name, int errsBefore);
        if (errCount == errsBefore) begin
            $display("test %s: passed", name);
            testsPassed++;
        end else begin
            $display("test %s: failed with %0d errors", name, errCount - errsBefore);
            testsFailed++;
        end
    endtask

    initial begin
        int errsBefore;
        void'($urandom(32'h0c93_0f5f));
        rstN = 1'b0;
        mValid = 2'b00;
        sReady = 6'b0;
        for (int m = 0; m < 2; m++) begin
            actReq[m] = '0;
            mId[m] = '0;
            mAddr[m] = '0;
            mLen[m] = '0;
            mSize[m] = '0;
            mBurst[m] = '0;
            delivered[m] = 0;
        end
        issuePct = 100;
        forceReady = 1'b0;
        checkAlternate = 1'b0;
        errCount = 0;
        testsPassed = 0;
        testsFailed = 0;

        errsBefore = errCount;
        applyReset();
        repeat (4) stepCycle();
        finishTest("reset state", errsBefore);

        // one master, one transfer at a time
        errsBefore = errCount;
        for (int m = 0; m < 2; m++) begin
            for (int k = 0; k < 5; k++) begin
                queueRequest(m, makeRequest(addrInSlave(k)));
                drainTraffic();
            end
        end
        finishTest("routing", errsBefore);

        errsBefore = errCount;
        for (int i = 0; i < defaultCount / 2; i++) begin
            queueRequest(0, makeRequest(unmappedAddr()));
            queueRequest(1, makeRequest(unmappedAddr()));
        end
        drainTraffic();
        finishTest("default slave", errsBefore);

        // fresh reset so master 0 is favoured
        errsBefore = errCount;
        @(posedge clk);
        #2;
        applyReset();
        forceReady = 1'b1;
        checkAlternate = 1'b1;
        for (int i = 0; i < fairCount / 2; i++) begin
            queueRequest(0, makeRequest(randomAddr()));
            queueRequest(1, makeRequest(randomAddr()));
        end
        drainTraffic();
        forceReady = 1'b0;
        checkAlternate = 1'b0;
        finishTest("fair arbitration", errsBefore);

        errsBefore = errCount;
        issuePct = 70;
        delivered[0] = 0;
        delivered[1] = 0;
        for (int i = 0; i < randomCount / 2; i++) begin
            queueRequest(0, makeRequest(randomAddr()));
            queueRequest(1, makeRequest(randomAddr()));
        end
        drainTraffic();
        for (int m = 0; m < 2; m++) begin
            if (delivered[m] != randomCount / 2) begin
                reportError($sformatf("master %0d delivered %0d requests, expected %0d",
                    m, delivered[m], randomCount / 2));
            end
        end
        finishTest("back-pressure", errsBefore);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
            testsPassed, testsFailed, errCount);
        if (errCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: source/awArbiter.sv
`timescale 1ns/1ps

module awArbiter (
    input  logic            clk,
    input  logic            rstN,

    input  axiPkg::idT      awIdM0,
    input  axiPkg::addrT    awAddrM0,
    input  axiPkg::lenT     awLenM0,
    input  axiPkg::sizeT    awSizeM0,
    input  axiPkg::burstT   awBurstM0,
    input  logic            awValidM0,
    output logic            awReadyM0,

    input  axiPkg::idT      awIdM1,
    input  axiPkg::addrT    awAddrM1,
    input  axiPkg::lenT     awLenM1,
    input  axiPkg::sizeT    awSizeM1,
    input  axiPkg::burstT   awBurstM1,
    input  logic            awValidM1,
    output logic            awReadyM1,

    output axiPkg::slaveIdT grantId,
    output axiPkg::addrT    grantAddr,
    output axiPkg::lenT     grantLen,
    output axiPkg::sizeT    grantSize,
    output axiPkg::burstT   grantBurst,
    output logic            grantValid,
    input  logic            grantReady
);
    import axiPkg::*;

    arbState state;

    logic [$clog2(numMasters)-1:0] lockIdx;
    logic [$clog2(numMasters)-1:0] rrPtr;
    logic [$clog2(numMasters)-1:0] grantIdx;
    logic                          handshake;

    // choose the master that owns the channel this cycle
    always_comb begin
        if (state == locked) begin
            grantIdx = lockIdx;
        end else if (awValidM0 && awValidM1) begin
            // both requesting, round-robin pointer decides
            grantIdx = rrPtr;
        end else if (awValidM1) begin
            grantIdx = 1'b1;
        end else begin
            grantIdx = 1'b0;
        end
    end

    // payload mux, master index goes in front of the ID
    always_comb begin
        if (grantIdx == 1'b1) begin
            grantId    = {idT'(grantIdx), awIdM1};
            grantAddr  = awAddrM1;
            grantLen   = awLenM1;
            grantSize  = awSizeM1;
            grantBurst = awBurstM1;
            grantValid = awValidM1;
        end else begin
            grantId    = {idT'(grantIdx), awIdM0};
            grantAddr  = awAddrM0;
            grantLen   = awLenM0;
            grantSize  = awSizeM0;
            grantBurst = awBurstM0;
            grantValid = awValidM0;
        end
    end

    assign handshake = grantValid && grantReady;

    // ready only reaches the granted master
    assign awReadyM0 = handshake && (grantIdx == 1'b0);
    assign awReadyM1 = handshake && (grantIdx == 1'b1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= idle;
            lockIdx <= '0;
            rrPtr   <= '0;
        end else begin
            case (state)
                idle: begin
                    // slave stalled, hold the grant until it accepts
                    if (grantValid && !grantReady) begin
                        state   <= locked;
                        lockIdx <= grantIdx;
                    end
                end
                locked: begin
                    if (handshake) begin
                        state <= idle;
                    end
                end
            endcase

            // favour the other master next time
            if (handshake) begin
                rrPtr <= ~grantIdx;
            end
        end
    end

endmodule

// File: source/awDecoder.sv
`timescale 1ns/1ps

module awDecoder (
    input  logic         grantValid,
    input  axiPkg::addrT grantAddr,

    input  logic         awReadyS1,
    input  logic         awReadyS2,
    input  logic         awReadyS3,
    input  logic         awReadyS4,
    input  logic         awReadyS5,
    input  logic         awReadySD,

    output logic         awValidS1,
    output logic         awValidS2,
    output logic         awValidS3,
    output logic         awValidS4,
    output logic         awValidS5,
    output logic         awValidSD,

    output logic         grantReady
);
    import axiPkg::*;

    slaveSelT slaveSel;

    function automatic logic inRange(
        input addrT addr,
        input addrT base,
        input addrT limit
    );
        return (addr >= base) && (addr <= limit);
    endfunction

    // address map lookup
    always_comb begin
        if (inRange(grantAddr, s1Base, s1Limit)) begin
            slaveSel = selS1;
        end else if (inRange(grantAddr, s2Base, s2Limit)) begin
            slaveSel = selS2;
        end else if (inRange(grantAddr, s3Base, s3Limit)) begin
            slaveSel = selS3;
        end else if (inRange(grantAddr, s4Base, s4Limit)) begin
            slaveSel = selS4;
        end else if (inRange(grantAddr, s5Base, s5Limit)) begin
            slaveSel = selS5;
        end else begin
            // unmapped, goes to the default slave
            slaveSel = selSD;
        end
    end

    // one-hot valid fan-out
    assign awValidS1 = grantValid && (slaveSel == selS1);
    assign awValidS2 = grantValid && (slaveSel == selS2);
    assign awValidS3 = grantValid && (slaveSel == selS3);
    assign awValidS4 = grantValid && (slaveSel == selS4);
    assign awValidS5 = grantValid && (slaveSel == selS5);
    assign awValidSD = grantValid && (slaveSel == selSD);

    // ready back from the selected slave
    always_comb begin
        case (slaveSel)
            selS1:   grantReady = awReadyS1;
            selS2:   grantReady = awReadyS2;
            selS3:   grantReady = awReadyS3;
            selS4:   grantReady = awReadyS4;
            selS5:   grantReady = awReadyS5;
            default: grantReady = awReadySD;
        endcase
    end

endmodule

// File: source/axiPkg.sv
package axiPkg;

    // master-side and slave-side transaction IDs
    typedef logic [3:0] idT;
    // upper nibble carries the master index
    typedef logic [7:0] slaveIdT;

    typedef logic [31:0] addrT;
    typedef logic [3:0]  lenT;
    typedef logic [2:0]  sizeT;
    typedef logic [1:0]  burstT;

    // 1 to 5 are mapped slaves, 6 is the default slave
    typedef logic [2:0] slaveSelT;

    localparam int numMasters = 2;

    localparam slaveSelT selS1 = 3'd1;
    localparam slaveSelT selS2 = 3'd2;
    localparam slaveSelT selS3 = 3'd3;
    localparam slaveSelT selS4 = 3'd4;
    localparam slaveSelT selS5 = 3'd5;
    localparam slaveSelT selSD = 3'd6;

    // slave address map, limits inclusive
    localparam addrT s1Base  = 32'h0000_0000;
    localparam addrT s1Limit = 32'h0000_FFFF;

    localparam addrT s2Base  = 32'h0001_0000;
    localparam addrT s2Limit = 32'h0001_FFFF;

    localparam addrT s3Base  = 32'h1000_0000;
    localparam addrT s3Limit = 32'h1000_03FF;

    localparam addrT s4Base  = 32'h1001_0000;
    localparam addrT s4Limit = 32'h1001_03FF;

    localparam addrT s5Base  = 32'h2000_0000;
    localparam addrT s5Limit = 32'h201F_FFFF;

    // arbiter FSM
    typedef enum logic {
        idle,
        locked
    } arbState;

endpackage

// File: source/writeAddrChannel.sv
`timescale 1ns/1ps

module writeAddrChannel (
    input  logic            clk,
    input  logic            rstN,

    // instruction-side master
    input  axiPkg::idT      awIdM0,
    input  axiPkg::addrT    awAddrM0,
    input  axiPkg::lenT     awLenM0,
    input  axiPkg::sizeT    awSizeM0,
    input  axiPkg::burstT   awBurstM0,
    input  logic            awValidM0,
    output logic            awReadyM0,

    // data-memory master
    input  axiPkg::idT      awIdM1,
    input  axiPkg::addrT    awAddrM1,
    input  axiPkg::lenT     awLenM1,
    input  axiPkg::sizeT    awSizeM1,
    input  axiPkg::burstT   awBurstM1,
    input  logic            awValidM1,
    output logic            awReadyM1,

    output axiPkg::slaveIdT awIdS1,
    output axiPkg::addrT    awAddrS1,
    output axiPkg::lenT     awLenS1,
    output axiPkg::sizeT    awSizeS1,
    output axiPkg::burstT   awBurstS1,
    output logic            awValidS1,
    input  logic            awReadyS1,

    output axiPkg::slaveIdT awIdS2,
    output axiPkg::addrT    awAddrS2,
    output axiPkg::lenT     awLenS2,
    output axiPkg::sizeT    awSizeS2,
    output axiPkg::burstT   awBurstS2,
    output logic            awValidS2,
    input  logic            awReadyS2,

    output axiPkg::slaveIdT awIdS3,
    output axiPkg::addrT    awAddrS3,
    output axiPkg::lenT     awLenS3,
    output axiPkg::sizeT    awSizeS3,
    output axiPkg::burstT   awBurstS3,
    output logic            awValidS3,
    input  logic            awReadyS3,

    output axiPkg::slaveIdT awIdS4,
    output axiPkg::addrT    awAddrS4,
    output axiPkg::lenT     awLenS4,
    output axiPkg::sizeT    awSizeS4,
    output axiPkg::burstT   awBurstS4,
    output logic            awValidS4,
    input  logic            awReadyS4,

    output axiPkg::slaveIdT awIdS5,
    output axiPkg::addrT    awAddrS5,
    output axiPkg::lenT     awLenS5,
    output axiPkg::sizeT    awSizeS5,
    output axiPkg::burstT   awBurstS5,
    output logic            awValidS5,
    input  logic            awReadyS5,

    // default slave
    output axiPkg::slaveIdT awIdSD,
    output axiPkg::addrT    awAddrSD,
    output axiPkg::lenT     awLenSD,
    output axiPkg::sizeT    awSizeSD,
    output axiPkg::burstT   awBurstSD,
    output logic            awValidSD,
    input  logic            awReadySD
);
    import axiPkg::*;

    slaveIdT grantId;
    addrT    grantAddr;
    lenT     grantLen;
    sizeT    grantSize;
    burstT   grantBurst;
    logic    grantValid;
    logic    grantReady;

    // payload goes to every slave, only valid is decoded
    assign awIdS1    = grantId;
    assign awAddrS1  = grantAddr;
    assign awLenS1   = grantLen;
    assign awSizeS1  = grantSize;
    assign awBurstS1 = grantBurst;

    assign awIdS2    = grantId;
    assign awAddrS2  = grantAddr;
    assign awLenS2   = grantLen;
    assign awSizeS2  = grantSize;
    assign awBurstS2 = grantBurst;

    assign awIdS3    = grantId;
    assign awAddrS3  = grantAddr;
    assign awLenS3   = grantLen;
    assign awSizeS3  = grantSize;
    assign awBurstS3 = grantBurst;

    assign awIdS4    = grantId;
    assign awAddrS4  = grantAddr;
    assign awLenS4   = grantLen;
    assign awSizeS4  = grantSize;
    assign awBurstS4 = grantBurst;

    assign awIdS5    = grantId;
    assign awAddrS5  = grantAddr;
    assign awLenS5   = grantLen;
    assign awSizeS5  = grantSize;
    assign awBurstS5 = grantBurst;

    assign awIdSD    = grantId;
    assign awAddrSD  = grantAddr;
    assign awLenSD   = grantLen;
    assign awSizeSD  = grantSize;
    assign awBurstSD = grantBurst;

    awArbiter awArbiter_i (
        .clk        (clk),
        .rstN       (rstN),
        .awIdM0     (awIdM0),
        .awAddrM0   (awAddrM0),
        .awLenM0    (awLenM0),
        .awSizeM0   (awSizeM0),
        .awBurstM0  (awBurstM0),
        .awValidM0  (awValidM0),
        .awReadyM0  (awReadyM0),
        .awIdM1     (awIdM1),
        .awAddrM1   (awAddrM1),
        .awLenM1    (awLenM1),
        .awSizeM1   (awSizeM1),
        .awBurstM1  (awBurstM1),
        .awValidM1  (awValidM1),
        .awReadyM1  (awReadyM1),
        .grantId    (grantId),
        .grantAddr  (grantAddr),
        .grantLen   (grantLen),
        .grantSize  (grantSize),
        .grantBurst (grantBurst),
        .grantValid (grantValid),
        .grantReady (grantReady)
    );

    awDecoder awDecoder_i (
        .grantValid (grantValid),
        .grantAddr  (grantAddr),
        .awReadyS1  (awReadyS1),
        .awReadyS2  (awReadyS2),
        .awReadyS3  (awReadyS3),
        .awReadyS4  (awReadyS4),
        .awReadyS5  (awReadyS5),
        .awReadySD  (awReadySD),
        .awValidS1  (awValidS1),
        .awValidS2  (awValidS2),
        .awValidS3  (awValidS3),
        .awValidS4  (awValidS4),
        .awValidS5  (awValidS5),
        .awValidSD  (awValidSD),
        .grantReady (grantReady)
    );

endmodule
